/* Bender.yml */
package:
  name: dcache

sources:
  - hw/dcacheCfgPkg.sv
  - hw/dcacheTypesPkg.sv
  - hw/tagLookupIf.sv
  - hw/lineAccessIf.sv
  - hw/distRam.sv
  - hw/dcacheTagArray.sv
  - hw/dcacheLineStore.sv
  - hw/dcacheCtrl.sv
  - hw/dcacheTop.sv
  - target: simulation
    files:
      - tb/dcacheTb.sv

/* compile.f */
hw/dcacheCfgPkg.sv
hw/dcacheTypesPkg.sv
hw/tagLookupIf.sv
hw/lineAccessIf.sv
hw/distRam.sv
hw/dcacheTagArray.sv
hw/dcacheLineStore.sv
hw/dcacheCtrl.sv
hw/dcacheTop.sv
tb/dcacheTb.sv

/* hw/dcacheCfgPkg.sv */
// L1 data cache geometry
// address split, way count, lane layout and replacement LFSR seed
`default_nettype none

package dcacheCfgPkg;

	// ----------------------------------------
	// address split: tag | set | offset
	// ----------------------------------------
	localparam int adrWidth = 16;
	localparam int offsetBits = 5;
	localparam int setBits = 5;
	localparam int tagBits = 6;

	// 4 ways x 32 sets, line number is {way, set}
	localparam int numWays = 4;
	localparam int lineNoBits = 7;

	// 32 data bytes plus one lane for the fault code
	localparam int lineBytes = 32;
	localparam int laneCount = 33;
	localparam int wordBytes = 8;

	localparam logic [21:0] lfsrSeed = 22'h1B5E7;

endpackage

`default_nettype wire

/* hw/dcacheCtrl.sv */
// L1 data cache controller
// request accept, fill second cycle, read response register and word select
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic reqValid_i,
	input dcacheTypesPkg::cacheOpE reqOp_i,
	input wire logic [dcacheCfgPkg::adrWidth-1:0] reqAdr_i,
	input wire logic [dcacheCfgPkg::lineBytes-1:0] reqSel_i,
	input wire logic [dcacheCfgPkg::lineBytes*8-1:0] reqData_i,
	input dcacheTypesPkg::faultT reqFault_i,
	input wire logic respReady_i,
	output logic reqReady_o,
	output logic respValid_o,
	output logic respHit_o,
	output dcacheTypesPkg::wordT respData_o,
	output dcacheTypesPkg::faultT respFault_o,
	tagLookupIf.ctrl lookup,
	lineAccessIf.ctrl line
);
	import dcacheCfgPkg::*;
	import dcacheTypesPkg::*;

	logic accept;
	logic fillPend;
	lineNoT lineNoQ;
	logic [offsetBits-1:0] offsetQ;
	logic [lineBytes-1:0] selQ;
	lineT wdataQ;
	logic hitQ;
	logic [offsetBits:0] byteIdx;

	// stall for the fill data cycle and for a held response
	assign reqReady_o = !fillPend && (!respValid_o || respReady_i);
	assign accept = reqValid_i && reqReady_o;

	// tag strobes only in the accepting cycle
	assign lookup.adr = reqAdr_i;
	assign lookup.allocate = accept && (reqOp_i == opFill);
	assign lookup.invLine = accept && (reqOp_i == opInvLine);
	assign lookup.invAll = accept && (reqOp_i == opInvAll);

	// ----------------------------------------
	// control state
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			fillPend <= 1'b0;
			respValid_o <= 1'b0;
		end else begin
			fillPend <= accept && (reqOp_i == opFill);
			if (accept && (reqOp_i == opRead)) respValid_o <= 1'b1;
			else if (respReady_i) respValid_o <= 1'b0;
		end
	end

	// payload captured on every accept, line number is settled by then
	always_ff @(posedge clk) begin
		if (accept) begin
			lineNoQ <= lookup.lineNo;
			offsetQ <= reqAdr_i[offsetBits-1:0];
			hitQ <= lookup.hit;
			selQ <= reqSel_i;
			wdataQ <= {byteT'(reqFault_i), reqData_i};
		end
	end

	// data lands one cycle after the tag write, fault lane always written
	assign line.lineNo = lineNoQ;
	assign line.wr = fillPend;
	assign line.sel = {1'b1, selQ};
	assign line.wdata = wdataQ;

	// ----------------------------------------
	// response word, zero past the last data byte
	// ----------------------------------------
	always_comb begin
		respData_o = '0;
		byteIdx = '0;
		for (int b = 0; b < wordBytes; b++) begin
			byteIdx = {1'b0, offsetQ} + (offsetBits+1)'(b);
			if (byteIdx < lineBytes) begin
				respData_o[b*8 +: 8] = line.rdata[byteIdx[offsetBits-1:0]];
			end
		end
	end

	assign respHit_o = hitQ;
	assign respFault_o = line.rdata[lineBytes][$bits(faultT)-1:0];

	// held response must not move, the store output included
	assert property (@(posedge clk) disable iff (rst)
		respValid_o && !respReady_i |=> respValid_o && $stable(respHit_o)
		&& $stable(respData_o) && $stable(respFault_o));

	// fill data cycle blocks the port
	assert property (@(posedge clk) disable iff (rst)
		accept && (reqOp_i == opFill) |=> !accept);

endmodule

`default_nettype wire

/* hw/dcacheLineStore.sv */
// line memory for the L1 data cache
// one distributed RAM per byte lane, 128 lines deep
`timescale 1ns/1ps
`default_nettype none

module dcacheLineStore (
	input wire logic clk,
	lineAccessIf.store line
);
	import dcacheCfgPkg::*;
	import dcacheTypesPkg::*;

	// gathered lane outputs
	lineT laneQ;

	// ----------------------------------------
	// byte lanes, lane 32 holds the fault code
	// ----------------------------------------
	for (genvar k = 0; k < laneCount; k++) begin : gLane
		// each lane has its own write enable from sel
		distRam #(.entryT(byteT), .depth(2**lineNoBits)) uLaneRam (
			.clk(clk),
			.we_i(line.wr && line.sel[k]),
			.adr_i(line.lineNo),
			.d_i(line.wdata[k]),
			.q_o(laneQ[k])
		);
	end

	// whole line reads through at lineNo
	assign line.rdata = laneQ;

endmodule

`default_nettype wire

/* hw/dcacheTagArray.sv */
// four-way tag array for the L1 data cache
// tag RAMs per way, valid vectors, hit compare, victim choice, LFSR
`timescale 1ns/1ps
`default_nettype none

module dcacheTagArray (
	input wire logic clk,
	input wire logic rst,
	tagLookupIf.tags lookup
);
	import dcacheCfgPkg::*;
	import dcacheTypesPkg::*;

	setT setIdx;
	tagT adrTag;
	tagT wayTag [numWays];
	logic [numWays-1:0] wayValid;
	logic [numWays-1:0] wayHit;
	logic [numWays-1:0] wayWe;
	logic [numWays-1:0][2**setBits-1:0] validQ;
	logic [21:0] lfsrQ;
	logic [lineNoBits-setBits-1:0] hitWay;
	logic [lineNoBits-setBits-1:0] victimWay;
	logic missAlloc;

	// split the request address
	assign setIdx = lookup.adr[offsetBits +: setBits];
	assign adrTag = lookup.adr[adrWidth-1 -: tagBits];

	// ----------------------------------------
	// per-way tag storage and compare
	// ----------------------------------------
	for (genvar w = 0; w < numWays; w++) begin : gWay
		distRam #(.entryT(tagT), .depth(2**setBits)) uTagRam (
			.clk(clk),
			.we_i(wayWe[w]),
			.adr_i(setIdx),
			.d_i(adrTag),
			.q_o(wayTag[w])
		);
		assign wayValid[w] = validQ[w][setIdx];
		assign wayHit[w] = wayValid[w] && (wayTag[w] == adrTag);
		// only the victim way takes the new tag
		assign wayWe[w] = missAlloc && (victimWay == (lineNoBits-setBits)'(w));
	end

	assign lookup.hit = |wayHit;
	assign missAlloc = lookup.allocate && !lookup.hit;

	// hit way encode, zero when nothing hits
	always_comb begin
		hitWay = '0;
		for (int w = 0; w < numWays; w++) begin
			if (wayHit[w]) hitWay = (lineNoBits-setBits)'(w);
		end
	end

	// lowest invalid way first, random way once the set is full
	always_comb begin
		victimWay = lfsrQ[lineNoBits-setBits-1:0];
		for (int w = numWays-1; w >= 0; w--) begin
			if (!wayValid[w]) victimWay = (lineNoBits-setBits)'(w);
		end
	end

	assign lookup.lineNo = missAlloc ? {victimWay, setIdx} : {hitWay, setIdx};

	// ----------------------------------------
	// valid bits and replacement LFSR
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= '0;
			lfsrQ <= lfsrSeed;
		end else begin
			// x^22 + x^21 + 1, free running
			lfsrQ <= {lfsrQ[20:0], lfsrQ[21] ^ lfsrQ[20]};
			if (lookup.invAll) begin
				validQ <= '0;
			end else if (lookup.invLine) begin
				for (int w = 0; w < numWays; w++) begin
					if (wayHit[w]) validQ[w][setIdx] <= 1'b0;
				end
			end else if (missAlloc) begin
				validQ[victimWay][setIdx] <= 1'b1;
			end
		end
	end

	// allocation never leaves two ways holding the same tag
	assert property (@(posedge clk) disable iff (rst) $onehot0(wayHit));

endmodule

`default_nettype wire

/* hw/dcacheTop.sv */
// L1 data cache top level
// plain request/response ports, controller, tag array and line store
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
	input wire logic clk,
	input wire logic rst,
	input wire logic reqValid_i,
	input dcacheTypesPkg::cacheOpE reqOp_i,
	input wire logic [dcacheCfgPkg::adrWidth-1:0] reqAdr_i,
	input wire logic [dcacheCfgPkg::lineBytes-1:0] reqSel_i,
	input wire logic [dcacheCfgPkg::lineBytes*8-1:0] reqData_i,
	input dcacheTypesPkg::faultT reqFault_i,
	input wire logic respReady_i,
	output logic reqReady_o,
	output logic respValid_o,
	output logic respHit_o,
	output dcacheTypesPkg::wordT respData_o,
	output dcacheTypesPkg::faultT respFault_o
);

	// internal links
	tagLookupIf lookup ();
	lineAccessIf line ();

	dcacheCtrl uCtrl (
		.clk(clk),
		.rst(rst),
		.reqValid_i(reqValid_i),
		.reqOp_i(reqOp_i),
		.reqAdr_i(reqAdr_i),
		.reqSel_i(reqSel_i),
		.reqData_i(reqData_i),
		.reqFault_i(reqFault_i),
		.respReady_i(respReady_i),
		.reqReady_o(reqReady_o),
		.respValid_o(respValid_o),
		.respHit_o(respHit_o),
		.respData_o(respData_o),
		.respFault_o(respFault_o),
		.lookup(lookup.ctrl),
		.line(line.ctrl)
	);

	// tags and valid bits
	dcacheTagArray uTags (.clk(clk), .rst(rst), .lookup(lookup.tags));

	// 128 lines of 33 lanes
	dcacheLineStore uStore (.clk(clk), .line(line.store));

endmodule

`default_nettype wire

/* hw/dcacheTypesPkg.sv */
// L1 data cache types
// request opcode, tag, line number, set, fault code and line/word layouts
`default_nettype none

package dcacheTypesPkg;

	// request kinds on the request port
	typedef enum logic [1:0] {
		opRead = 2'd0,
		opFill = 2'd1,
		opInvLine = 2'd2,
		opInvAll = 2'd3
	} cacheOpE;

	typedef logic [dcacheCfgPkg::tagBits-1:0] tagT;
	typedef logic [dcacheCfgPkg::lineNoBits-1:0] lineNoT;
	typedef logic [dcacheCfgPkg::setBits-1:0] setT;
	typedef logic [2:0] faultT;

	// one lane per byte, top lane carries the fault code
	typedef logic [7:0] byteT;
	typedef logic [dcacheCfgPkg::laneCount-1:0] lineSelT;
	typedef byteT [dcacheCfgPkg::laneCount-1:0] lineT;
	typedef logic [dcacheCfgPkg::wordBytes*8-1:0] wordT;

endpackage

`default_nettype wire

/* hw/distRam.sv */
// single-port distributed RAM
// clocked write, combinational read, entry type given by parameter
`timescale 1ns/1ps
`default_nettype none

module distRam #(
	parameter type entryT = logic,
	parameter int depth = 32
) (
	input wire logic clk,
	input wire logic we_i,
	input wire logic [$clog2(depth)-1:0] adr_i,
	input entryT d_i,
	output entryT q_o
);

	entryT mem [depth];

	// cleared contents for simulation, ignored by the fabric
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[adr_i] <= d_i;
		end
	end

	// read through in the same cycle
	assign q_o = mem[adr_i];

endmodule

`default_nettype wire

/* hw/lineAccessIf.sv */
// controller to line store link
// line number, byte-lane write and async read data
`timescale 1ns/1ps
`default_nettype none

interface lineAccessIf;
	import dcacheTypesPkg::*;

	lineNoT lineNo;
	logic wr;
	// per-lane write enables, lane 32 is the fault code
	lineSelT sel;
	lineT wdata;
	// reads through at lineNo
	lineT rdata;

	modport ctrl (output lineNo, wr, sel, wdata, input rdata);
	modport store (input lineNo, wr, sel, wdata, output rdata);

endinterface

`default_nettype wire

/* hw/tagLookupIf.sv */
// controller to tag array link
// address and strobes in, hit and line number out
`timescale 1ns/1ps
`default_nettype none

interface tagLookupIf;
	import dcacheCfgPkg::*;
	import dcacheTypesPkg::*;

	// request address, held for the whole strobed cycle
	logic [adrWidth-1:0] adr;
	// allocate on miss, or clear one hit way, or clear everything
	logic allocate;
	logic invLine;
	logic invAll;
	// combinational from adr
	logic hit;
	lineNoT lineNo;

	modport ctrl (output adr, allocate, invLine, invAll, input hit, lineNo);
	modport tags (input adr, allocate, invLine, invAll, output hit, lineNo);

endinterface

`default_nettype wire

/* tb/dcacheTb.sv */
// testbench for the L1 data cache
// LCG stimulus, shadow-memory model, reference read function,
// response checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;
	import dcacheCfgPkg::*;
	import dcacheTypesPkg::*;

	localparam int clkPeriod = 100;
	// fill-read 96, partial 32, miss 28, invalidate 46, back-pressure 44
	localparam int totalOps = 96 + 32 + 28 + 46 + 44;

	typedef struct packed {
		logic hit;
		wordT data;
		faultT fault;
	} respS;

	logic clk = 1'b0;
	logic rst;
	logic reqValid_i;
	cacheOpE reqOp_i;
	logic [adrWidth-1:0] reqAdr_i;
	logic [lineBytes-1:0] reqSel_i;
	logic [lineBytes*8-1:0] reqData_i;
	faultT reqFault_i;
	logic respReady_i;
	logic reqReady_o;
	logic respValid_o;
	logic respHit_o;
	wordT respData_o;
	faultT respFault_o;

	// shadow model, indexed by address bits 15:5
	logic resident [2048];
	logic [255:0] lineData [2048];
	faultT shadowFault [2048];
	int setCount [32];
	logic [5:0] baseTag [32];

	respS expQ[$];
	bit probeQ[$];
	string nameQ[$];
	bit probeHitQ[$];
	string testName;
	logic [31:0] rngState = 32'h7113_6984;
	logic [31:0] stallState = 32'h7113_6984;
	logic stallOn;
	logic reqTaken;
	logic readAccQ;
	logic heldQ;
	respS heldV;
	int mismatchCount = 0;
	int otherCount = 0;

	dcacheTop DUT (.*);

	always #(clkPeriod/2) clk = ~clk;

	// ----------------------------------------
	// random numbers and the reference model
	// ----------------------------------------
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] drawRand();
		rngState = lcgNext(rngState);
		return rngState;
	endfunction

	function automatic logic [255:0] randLine();
		logic [255:0] v;
		for (int i = 0; i < 8; i++) v[i*32 +: 32] = drawRand();
		return v;
	endfunction

	// tag number t of a set, distinct for t below 64
	function automatic logic [15:0] lineAdr(input int s, input int t, input int off);
		return {6'((baseTag[s] + 13*t) % 64), 5'(s), 5'(off)};
	endfunction

	// expected read: hit, 8 bytes from the offset padded with zero, fault
	function automatic respS refRead(input logic [15:0] adr);
		respS r;
		int blk;
		int off;
		blk = adr[15:5];
		off = adr[4:0];
		r.hit = resident[blk];
		r.fault = shadowFault[blk];
		r.data = '0;
		for (int b = 0; b < 8; b++) begin
			if (off + b < 32) r.data[b*8 +: 8] = lineData[blk][(off+b)*8 +: 8];
		end
		return r;
	endfunction

	task automatic compareField(input string name, input string field,
			input logic [63:0] expV, input logic [63:0] actV);
		assert (expV === actV) else begin
			mismatchCount++;
			$display("mismatch %s %s: expected %h actual %h", name, field, expV, actV);
		end
	endtask

	// ----------------------------------------
	// request driver, called on a falling edge
	// ----------------------------------------
	task automatic sendReq(input cacheOpE op, input logic [15:0] adr, input logic [31:0] sel,
			input logic [255:0] data, input faultT fault);
		reqValid_i = 1'b1;
		reqOp_i = op;
		reqAdr_i = adr;
		reqSel_i = sel;
		reqData_i = data;
		reqFault_i = fault;
		do @(negedge clk); while (!reqTaken);
		reqValid_i = 1'b0;
	endtask

	task automatic readLine(input logic [15:0] adr, input bit probe);
		expQ.push_back(refRead(adr));
		probeQ.push_back(probe);
		nameQ.push_back(testName);
		sendReq(opRead, adr, '0, '0, '0);
	endtask

	task automatic drain();
		while (expQ.size() != 0) @(negedge clk);
	endtask

	// victim is random in a full set, so read all five tags back
	task automatic resolveEviction(input int newBlk);
		int blkList[$];
		int hits;
		int newIdx;
		int setNo;
		setNo = newBlk % 32;
		newIdx = 0;
		for (int tg = 0; tg < 64; tg++) begin
			if (resident[tg*32 + setNo]) begin
				if (tg*32 + setNo == newBlk) newIdx = blkList.size();
				blkList.push_back(tg*32 + setNo);
			end
		end
		probeHitQ.delete();
		foreach (blkList[i]) readLine(16'(blkList[i] << 5), 1'b1);
		drain();
		hits = 0;
		foreach (blkList[i]) begin
			if (probeHitQ[i]) hits++;
			else resident[blkList[i]] = 1'b0;
		end
		setCount[setNo] = hits;
		compareField(testName, "hit count", 64'd4, 64'(hits));
		assert (probeHitQ[newIdx]) else begin
			otherCount++;
			$display("%s: the newly filled line does not hit", testName);
		end
	endtask

	// a new line always takes a full select so the model knows every byte
	task automatic fillLine(input logic [15:0] adr, input logic [31:0] sel,
			input logic [255:0] data, input faultT fault);
		int blk;
		bit needEvict;
		blk = adr[15:5];
		needEvict = 1'b0;
		if (!resident[blk]) begin
			sel = '1;
			if (setCount[blk % 32] == numWays) needEvict = 1'b1;
			else setCount[blk % 32]++;
			resident[blk] = 1'b1;
		end
		for (int b = 0; b < 32; b++) begin
			if (sel[b]) lineData[blk][b*8 +: 8] = data[b*8 +: 8];
		end
		shadowFault[blk] = fault;
		sendReq(opFill, adr, sel, data, fault);
		if (needEvict) resolveEviction(blk);
	endtask

	task automatic invalidateLine(input logic [15:0] adr);
		if (resident[adr[15:5]]) begin
			resident[adr[15:5]] = 1'b0;
			setCount[adr[9:5]]--;
		end
		sendReq(opInvLine, adr, '0, '0, '0);
	endtask

	task automatic invalidateAll();
		foreach (resident[i]) resident[i] = 1'b0;
		foreach (setCount[i]) setCount[i] = 0;
		sendReq(opInvAll, '0, '0, '0, '0);
	endtask

	// ----------------------------------------
	// response checker and handshake monitor
	// ----------------------------------------
	always @(posedge clk) begin : compareResp
		respS expV;
		bit probeV;
		string nameV;
		if (rst) begin
			reqTaken <= 1'b0;
			readAccQ <= 1'b0;
			heldQ <= 1'b0;
		end else begin
			if (heldQ) begin
				assert (respValid_o && {respHit_o, respData_o, respFault_o} === heldV) else begin
					otherCount++;
					$display("held response changed or dropped while respReady_i was low");
				end
			end
			if (respValid_o && !respReady_i) begin
				assert (!reqReady_o) else begin
					otherCount++;
					$display("request port ready while a response was held");
				end
			end
			if (readAccQ) begin
				assert (respValid_o) else begin
					otherCount++;
					$display("no response in the cycle after a read was accepted");
				end
			end
			reqTaken <= reqValid_i && reqReady_o;
			readAccQ <= reqValid_i && reqReady_o && (reqOp_i == opRead);
			heldQ <= respValid_o && !respReady_i;
			heldV <= {respHit_o, respData_o, respFault_o};
			if (respValid_o && respReady_i) begin
				if (expQ.size() == 0) begin
					otherCount++;
					$display("response arrived with no outstanding read");
				end else begin
					expV = expQ.pop_front();
					probeV = probeQ.pop_front();
					nameV = nameQ.pop_front();
					if (probeV) probeHitQ.push_back(respHit_o);
					else compareField(nameV, "hit", 64'(expV.hit), 64'(respHit_o));
					if (respHit_o && (expV.hit || probeV)) begin
						compareField(nameV, "data", expV.data, respData_o);
						compareField(nameV, "fault", 64'(expV.fault), 64'(respFault_o));
					end
				end
			end
		end
	end

	// random stalls of the response port, low about one cycle in four
	always @(negedge clk) begin
		stallState = lcgNext(stallState);
		respReady_i = !stallOn || (stallState[31:30] != 2'b00);
	end

	initial begin
		#(totalOps * 20 * clkPeriod);
		$display("timeout: run did not finish within %0d cycles", totalOps * 20);
		$display("Done: errors found");
		$finish;
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] r;
		rst = 1'b1;
		reqValid_i = 1'b0;
		reqOp_i = opRead;
		reqAdr_i = '0;
		reqSel_i = '0;
		reqData_i = '0;
		reqFault_i = '0;
		respReady_i = 1'b1;
		stallOn = 1'b0;
		foreach (resident[i]) resident[i] = 1'b0;
		foreach (setCount[i]) setCount[i] = 0;
		foreach (baseTag[i]) baseTag[i] = drawRand() >> 26;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		testName = "fill-read";
		for (int s = 0; s < 8; s++) begin
			for (int t = 0; t < 4; t++) fillLine(lineAdr(s, t, 0), '1, randLine(), 3'(drawRand()));
		end
		repeat (64) begin
			r = drawRand();
			readLine(lineAdr(r[31:29], r[28:27], r[26:22]), 1'b0);
		end
		drain();

		testName = "partial-fill";
		repeat (16) begin
			r = drawRand();
			fillLine(lineAdr(r[31:29], r[28:27], 0), drawRand(), randLine(), r[2:0]);
			readLine(lineAdr(r[31:29], r[28:27], r[26:22]), 1'b0);
		end
		drain();

		// tags 5 to 7 of the used sets and all of sets 16 up were never filled
		testName = "miss";
		repeat (16) begin
			r = drawRand();
			if (r[0]) readLine(lineAdr(r[31:29], 5 + r[28:27] % 3, r[26:22]), 1'b0);
			else readLine(lineAdr(16 + r[31:28], r[27:22], r[4:0]), 1'b0);
		end
		drain();
		testName = "fifth-tag";
		fillLine(lineAdr(0, 4, 0), '1, randLine(), 3'(drawRand()));
		fillLine(lineAdr(1, 4, 0), '1, randLine(), 3'(drawRand()));

		testName = "inv-line";
		invalidateLine(lineAdr(2, 1, 0));
		for (int t = 0; t < 4; t++) readLine(lineAdr(2, t, 8), 1'b0);
		drain();
		testName = "inv-all";
		invalidateAll();
		for (int s = 0; s < 8; s++) begin
			for (int t = 0; t < 5; t++) readLine(lineAdr(s, t, 0), 1'b0);
		end
		drain();

		testName = "back-pressure";
		stallOn = 1'b1;
		for (int s = 0; s < 4; s++) fillLine(lineAdr(s, 0, 0), '1, randLine(), 3'(drawRand()));
		repeat (40) begin
			r = drawRand();
			readLine(lineAdr(r[31:30], r[29], r[28:24]), 1'b0);
		end
		drain();
		stallOn = 1'b0;
		repeat (4) @(negedge clk);

		$display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
		if (mismatchCount + otherCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
